//--- hdl/tcb_params.svh
// bus widths, response delay and memory depth; include in every file that sizes a bus signal
`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

`default_nettype none

////////////////////////////////////////////////////////////////////////////
// bus geometry
////////////////////////////////////////////////////////////////////////////

// byte address width
`define TCB_ADR_W 16

// data width, a whole number of bytes
`define TCB_DAT_W 32

// byte lanes per data word and the address bits that select a lane
`define TCB_BEN_W (`TCB_DAT_W/8)
`define TCB_OFF_W ($clog2(`TCB_BEN_W))

////////////////////////////////////////////////////////////////////////////
// timing and storage
////////////////////////////////////////////////////////////////////////////

// cycles from a transfer to its response
`define TCB_DLY 1

// number of words in the subordinate memory
`define TCB_MEM_DEPTH 64

`default_nettype wire

`endif

//--- hdl/tcb_pkg.sv
// bus-protocol types shared by the manager side of the TCB converter and the top level
`include "tcb_params.svh"
`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////////
  // transfer attributes
  //////////////////////////////////////////////////////////////////////////

  // byte order of a transfer
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } ndn_t;

  // log2 of the access size in bytes
  // 0 byte, 1 half word, 2 word
  typedef logic [1:0] siz_t;

  //////////////////////////////////////////////////////////////////////////
  // request and response
  //////////////////////////////////////////////////////////////////////////

  // log-size request as sent by the outside manager
  // write bytes sit from bit 0 upward in access order
  typedef struct packed {
    logic                  wen;  // write enable
    ndn_t                  ndn;  // endianness
    siz_t                  siz;  // access size
    logic [`TCB_ADR_W-1:0] adr;  // byte address, aligned to siz
    logic [`TCB_DAT_W-1:0] wdt;  // write data
  } req_t;

  // response, valid a fixed delay after the transfer
  typedef struct packed {
    logic [`TCB_DAT_W-1:0] rdt;  // read data
    logic                  sts;  // 1 when the address is out of range
  } rsp_t;

endpackage : tcb_pkg

`default_nettype wire

//--- hdl/tcb_mem_pkg.sv
// memory-side types: byte-enable requests and the record that follows a transfer to its response
`include "tcb_params.svh"
`default_nettype none

package tcb_mem_pkg;

  //////////////////////////////////////////////////////////////////////////
  // byte-enable request
  //////////////////////////////////////////////////////////////////////////

  // request after conversion, lanes already placed
  typedef struct packed {
    logic                  wen;  // write enable
    logic [`TCB_BEN_W-1:0] ben;  // one bit per byte lane
    logic [`TCB_ADR_W-1:0] adr;  // word aligned address
    logic [`TCB_DAT_W-1:0] wdt;  // lane data, zero on disabled lanes
  } mem_req_t;

  //////////////////////////////////////////////////////////////////////////
  // response tracking
  //////////////////////////////////////////////////////////////////////////

  // what the converter needs to undo the lane rotation on read data
  typedef struct packed {
    logic [`TCB_OFF_W-1:0] off;  // lane offset of the request
    tcb_pkg::ndn_t         ndn;  // byte order of the request
  } trk_t;

endpackage : tcb_mem_pkg

`default_nettype wire

//--- hdl/tcb_dly_pipe.sv
// fixed-depth delay line for any payload type, lines a record up with a delayed response
`timescale 1ns/1ps
`include "tcb_params.svh"
`default_nettype none

module tcb_dly_pipe #(
  parameter int unsigned DLY = `TCB_DLY,  // stages between din and dout
  parameter type         T   = logic      // payload carried through the stages
) (
  input  wire logic clk,
  input  wire logic arst_n,
  input  wire T     din,
  output T          dout
);

  generate
    if (DLY == 0) begin : g_bypass

      // zero depth, payload goes straight through
      assign dout = din;

    end else begin : g_pipe

      // one payload per stage, several items can be in flight
      T stg [DLY];

      always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
          for (int unsigned i = 0; i < DLY; i++) begin
            stg[i] <= '0;
          end
        end else begin
          stg[0] <= din;
          // shift toward the output every cycle
          for (int unsigned i = 1; i < DLY; i++) begin
            stg[i] <= stg[i-1];
          end
        end
      end

      // last stage is the delayed payload
      assign dout = stg[DLY-1];

    end
  endgenerate

endmodule : tcb_dly_pipe

`default_nettype wire

//--- hdl/tcb_lib_logsize2byteena.sv
// converts log-size TCB requests to byte-enable requests with endian lane rotation both ways
`timescale 1ns/1ps
`include "tcb_params.svh"
`default_nettype none

module tcb_lib_logsize2byteena (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  // subordinate port facing the outside manager
  input  wire logic                  sub_vld,
  input  wire tcb_pkg::req_t         sub_req,
  output logic                       sub_rdy,
  output tcb_pkg::rsp_t              sub_rsp,
  // manager port facing the memory
  output logic                       man_vld,
  output tcb_mem_pkg::mem_req_t      man_req,
  input  wire logic                  man_rdy,
  input  wire tcb_pkg::rsp_t         man_rsp
);

  localparam int unsigned BEN = `TCB_BEN_W;
  localparam int unsigned OFF = `TCB_OFF_W;
  localparam int unsigned ADR = `TCB_ADR_W;

  // data as byte lanes
  logic [BEN-1:0][7:0] req_wdt_b;  // access order bytes
  logic [BEN-1:0][7:0] man_wdt_l;  // lane order bytes
  logic [BEN-1:0][7:0] man_rdt_l;  // lane order bytes
  logic [BEN-1:0][7:0] rsp_rdt_b;  // access order bytes

  // lanes touched by the request
  logic [BEN-1:0] req_ben;

  // lane offset of the request
  logic [OFF-1:0] req_off;

  // transfer strobe and tracking records
  logic              xfer;
  tcb_mem_pkg::trk_t trk_req;
  tcb_mem_pkg::trk_t trk_rsp;

  ////////////////////////////////////////////////////////////////////////////
  // handshake and address
  ////////////////////////////////////////////////////////////////////////////

  // vld and rdy pass straight through
  assign man_vld = sub_vld;
  assign sub_rdy = man_rdy;
  assign xfer    = sub_vld & man_rdy;

  assign man_req.wen = sub_req.wen;

  // low address bits select the lane and the memory sees a word address
  assign req_off     = sub_req.adr[OFF-1:0];
  assign man_req.adr = {sub_req.adr[ADR-1:OFF], OFF'(0)};

  ////////////////////////////////////////////////////////////////////////////
  // request lane rotation
  ////////////////////////////////////////////////////////////////////////////

  assign req_wdt_b = sub_req.wdt;

  // for each lane find the access byte k that lands on it
  // k = lane - off for little endian and k = off - lane for big endian (mod BEN)
  always_comb begin
    logic [OFF-1:0] k;
    for (int unsigned i = 0; i < BEN; i++) begin
      if (sub_req.ndn == tcb_pkg::TCB_BIG) begin
        k = req_off - OFF'(i);
      end else begin
        k = OFF'(i) - req_off;
      end
      // lane enabled when k falls inside the access size
      req_ben[i]   = (int'(k) < (1 << sub_req.siz));
      man_wdt_l[i] = req_ben[i] ? req_wdt_b[k] : 8'h00;
    end
  end

  assign man_req.ben = req_ben;
  assign man_req.wdt = man_wdt_l;

  ////////////////////////////////////////////////////////////////////////////
  // response tracking
  ////////////////////////////////////////////////////////////////////////////

  // capture offset and byte order only on a real transfer
  assign trk_req = xfer ? tcb_mem_pkg::trk_t'{off: req_off, ndn: sub_req.ndn} : '0;

  // record arrives together with the memory response
  tcb_dly_pipe #(
    .DLY (`TCB_DLY),
    .T   (tcb_mem_pkg::trk_t)
  ) u_trk_pipe (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (trk_req),
    .dout   (trk_rsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // response lane rotation
  ////////////////////////////////////////////////////////////////////////////

  assign man_rdt_l = man_rsp.rdt;

  // exact inverse of the request mapping where byte k reads lane off+k or off-k
  // disabled lanes come back zero from the memory so bytes past the size stay zero
  always_comb begin
    logic [OFF-1:0] lane;
    for (int unsigned k = 0; k < BEN; k++) begin
      if (trk_rsp.ndn == tcb_pkg::TCB_BIG) begin
        lane = trk_rsp.off - OFF'(k);
      end else begin
        lane = trk_rsp.off + OFF'(k);
      end
      rsp_rdt_b[k] = man_rdt_l[lane];
    end
  end

  assign sub_rsp.rdt = rsp_rdt_b;

  // status is not touched by the conversion
  assign sub_rsp.sts = man_rsp.sts;

endmodule : tcb_lib_logsize2byteena

`default_nettype wire

//--- hdl/tcb_mem_sub.sv
// byte-enable TCB memory subordinate, clears itself after reset and answers after a fixed delay
`timescale 1ns/1ps
`include "tcb_params.svh"
`default_nettype none

module tcb_mem_sub (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic                  vld,
  input  wire tcb_mem_pkg::mem_req_t req,
  output logic                       rdy,
  output tcb_pkg::rsp_t              rsp
);

  localparam int unsigned BEN   = `TCB_BEN_W;
  localparam int unsigned OFF   = `TCB_OFF_W;
  localparam int unsigned ADR   = `TCB_ADR_W;
  localparam int unsigned DEPTH = `TCB_MEM_DEPTH;
  localparam int unsigned IDX_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = IDX_W + 1;
  localparam int unsigned WRD_W = ADR - OFF;

  // word storage, byte lanes packed
  logic [BEN-1:0][7:0] mem_arr [DEPTH];

  // clear sequencer
  logic [CNT_W-1:0] clr_cnt;
  logic             clr_act;

  // request decode
  logic                xfer;
  logic [WRD_W-1:0]    wrd;
  logic [IDX_W-1:0]    idx;
  logic                in_rng;
  logic [BEN-1:0][7:0] wdt_l;
  logic [BEN-1:0][7:0] rdt_l;
  tcb_pkg::rsp_t       rsp_now;

  ////////////////////////////////////////////////////////////////////////////
  // clear after reset
  ////////////////////////////////////////////////////////////////////////////

  // one word per cycle, rdy stays low until the count reaches DEPTH
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clr_cnt <= '0;
    end else if (clr_act) begin
      clr_cnt <= clr_cnt + 1'b1;
    end
  end

  assign rdy     = (clr_cnt == CNT_W'(DEPTH));
  assign clr_act = !rdy;
  assign xfer    = vld & rdy;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  // word index from the aligned address, range checked against the depth
  assign wrd    = req.adr[ADR-1:OFF];
  assign in_rng = (wrd < WRD_W'(DEPTH));
  assign idx    = wrd[IDX_W-1:0];
  assign wdt_l  = req.wdt;

  ////////////////////////////////////////////////////////////////////////////
  // array access
  ////////////////////////////////////////////////////////////////////////////

  // clear has the array to itself, no transfer can happen meanwhile
  always_ff @(posedge clk) begin
    if (clr_act) begin
      mem_arr[clr_cnt[IDX_W-1:0]] <= '0;
    end else if (xfer && req.wen && in_rng) begin
      // out of range writes are dropped
      for (int unsigned i = 0; i < BEN; i++) begin
        if (req.ben[i]) begin
          mem_arr[idx][i] <= wdt_l[i];
        end
      end
    end
  end

  // read before write, only enabled lanes return data
  always_comb begin
    for (int unsigned i = 0; i < BEN; i++) begin
      rdt_l[i] = (in_rng && req.ben[i]) ? mem_arr[idx][i] : 8'h00;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  // idle cycles push zero into the pipe
  assign rsp_now.rdt = xfer ? rdt_l : '0;
  assign rsp_now.sts = xfer & ~in_rng;

  tcb_dly_pipe #(
    .DLY (`TCB_DLY),
    .T   (tcb_pkg::rsp_t)
  ) u_rsp_pipe (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (rsp_now),
    .dout   (rsp)
  );

endmodule : tcb_mem_sub

`default_nettype wire

//--- hdl/tcb_sys_top.sv
// top level of the TCB memory subsystem, log-size converter in front of a byte-enable memory
`timescale 1ns/1ps
`include "tcb_params.svh"
`default_nettype none

module tcb_sys_top (
  input  wire logic          clk,
  input  wire logic          arst_n,
  // outside manager
  input  wire logic          sub_vld,
  input  wire tcb_pkg::req_t sub_req,
  output logic               sub_rdy,
  output tcb_pkg::rsp_t      sub_rsp
);

  ////////////////////////////////////////////////////////////////////////////
  // converter to memory link
  ////////////////////////////////////////////////////////////////////////////

  logic                  man_vld;
  tcb_mem_pkg::mem_req_t man_req;
  logic                  man_rdy;
  tcb_pkg::rsp_t         man_rsp;

  // size and lane conversion
  tcb_lib_logsize2byteena u_conv (
    .clk     (clk),
    .arst_n  (arst_n),
    .sub_vld (sub_vld),
    .sub_req (sub_req),
    .sub_rdy (sub_rdy),
    .sub_rsp (sub_rsp),
    .man_vld (man_vld),
    .man_req (man_req),
    .man_rdy (man_rdy),
    .man_rsp (man_rsp)
  );

  // word memory, sole source of back-pressure
  tcb_mem_sub u_mem (
    .clk    (clk),
    .arst_n (arst_n),
    .vld    (man_vld),
    .req    (man_req),
    .rdy    (man_rdy),
    .rsp    (man_rsp)
  );

endmodule : tcb_sys_top

`default_nettype wire

//--- tb/tcb_sys_properties.sv
// concurrent checks on handshake, byte enables and status of the TCB subsystem, bound to the top level
`timescale 1ns/1ps
`include "tcb_params.svh"
`default_nettype none

module tcb_sys_properties (
  input wire logic                  clk,
  input wire logic                  arst_n,
  input wire logic                  sub_vld,
  input wire tcb_pkg::req_t         sub_req,
  input wire logic                  sub_rdy,
  input wire tcb_pkg::rsp_t         sub_rsp,
  input wire tcb_mem_pkg::mem_req_t man_req
);

  localparam int unsigned DEPTH = `TCB_MEM_DEPTH;
  localparam int unsigned CNT_W = $clog2(DEPTH) + 1;

  // cycles since reset release, stops once the clear is over
  logic [CNT_W-1:0] clr_cyc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clr_cyc <= '0;
    end else if (clr_cyc != CNT_W'(DEPTH)) begin
      clr_cyc <= clr_cyc + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////////////////////

  // one enabled lane per byte of the access
  a_ben_count: assert property (
    @(posedge clk) disable iff (!arst_n)
    sub_vld |-> ($countones(man_req.ben) == (1 << sub_req.siz))
  ) else $error("byte enable count differs from the access size");

  // no transfer can be accepted while words are still being zeroed
  a_rdy_clear: assert property (
    @(posedge clk) disable iff (!arst_n)
    (clr_cyc < CNT_W'(DEPTH)) |-> !sub_rdy
  ) else $error("rdy high while the memory is still clearing");

  // out of range responses carry no data
  a_sts_rdt: assert property (
    @(posedge clk) disable iff (!arst_n)
    sub_rsp.sts |-> (sub_rsp.rdt == '0)
  ) else $error("status set with non-zero read data");

endmodule : tcb_sys_properties

`default_nettype wire

//--- tb/tcb_sys_tb.sv
// self-checking testbench that runs a request table through the TCB subsystem against a byte model
`timescale 1ns/1ps
`include "tcb_params.svh"
`default_nettype none

module tcb_sys_tb;

  localparam int unsigned BEN   = `TCB_BEN_W;
  localparam int unsigned DEPTH = `TCB_MEM_DEPTH;
  localparam int unsigned N_RND = 40;

  logic          clk = 1'b0;
  logic          arst_n;
  logic          sub_vld;
  tcb_pkg::req_t sub_req;
  logic          sub_rdy;
  tcb_pkg::rsp_t sub_rsp;

  // request table where name and request share the index
  string         tbl_name [$];
  tcb_pkg::req_t tbl_req  [$];
  logic          tbl_done = 1'b0;

  // responses owed by the DUT in order, each due on a cycle count
  string         exp_name [$];
  tcb_pkg::rsp_t exp_rsp  [$];
  int unsigned   exp_due  [$];

  string         cur_name;
  string         chk_name;
  tcb_pkg::rsp_t chk_rsp;
  int unsigned   cyc   = 0;
  int unsigned   wd_ns;
  logic [31:0]   lfsr  = 32'd97633;

  // byte model of the memory indexed by word * BEN + lane
  logic [7:0] shadow [DEPTH*BEN];

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  tcb_sys_top u_tcb_sys_top (
    .clk     (clk),
    .arst_n  (arst_n),
    .sub_vld (sub_vld),
    .sub_req (sub_req),
    .sub_rdy (sub_rdy),
    .sub_rsp (sub_rsp)
  );

  bind tcb_sys_top tcb_sys_properties u_props (
    .clk     (clk),
    .arst_n  (arst_n),
    .sub_vld (sub_vld),
    .sub_req (sub_req),
    .sub_rdy (sub_rdy),
    .sub_rsp (sub_rsp),
    .man_req (man_req)
  );

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // expected response from the lane rule with the write applied after the read
  function automatic tcb_pkg::rsp_t model_access(input tcb_pkg::req_t r);
    tcb_pkg::rsp_t exp;
    int unsigned   word;
    int unsigned   off;
    int unsigned   lane;
    exp  = '0;
    word = r.adr / BEN;
    off  = r.adr % BEN;
    if (word >= DEPTH) begin
      exp.sts = 1'b1;
    end else begin
      for (int unsigned k = 0; k < (1 << r.siz); k++) begin
        lane = (r.ndn == tcb_pkg::TCB_BIG) ? (off + BEN - k) % BEN : (off + k) % BEN;
        exp.rdt[8*k +: 8] = shadow[word*BEN + lane];
        if (r.wen) begin
          shadow[word*BEN + lane] = r.wdt[8*k +: 8];
        end
      end
    end
    return exp;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_rsp(input string name, input tcb_pkg::rsp_t exp, input tcb_pkg::rsp_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected rdt %h sts %b, actual rdt %h sts %b",
               name, exp.rdt, exp.sts, act.rdt, act.sts);
      $display("TEST RESULT: FAIL");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_rdy(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected rdy %b, actual rdy %b", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "ready mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // request table
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_entry(input string name, input logic wen, input tcb_pkg::ndn_t ndn,
                           input int unsigned siz, input int unsigned adr,
                           input logic [`TCB_DAT_W-1:0] wdt);
    tcb_pkg::req_t r;
    r.wen = wen;
    r.ndn = ndn;
    r.siz = tcb_pkg::siz_t'(siz);
    r.adr = `TCB_ADR_W'(adr);
    r.wdt = wdt;
    tbl_name.push_back(name);
    tbl_req.push_back(r);
  endtask

  task automatic build_table();
    int unsigned   s;
    int unsigned   o;
    int unsigned   w;
    logic          wen;
    tcb_pkg::ndn_t ndn;
    // every word reads zero once cleared
    for (w = 0; w < DEPTH; w++) begin
      add_entry($sformatf("clear_rd_w%0d", w), 1'b0, tcb_pkg::TCB_LITTLE, 2, w*BEN, '0);
    end
    // each size at each aligned offset with junk above the size that must be ignored
    for (s = 0; s < 3; s++) begin
      for (o = 0; o < BEN; o += (1 << s)) begin
        add_entry($sformatf("le_wr_s%0d_o%0d", s, o), 1'b1, tcb_pkg::TCB_LITTLE, s, 8 + o,
                  32'(32'h8C4A_E610 + s*16 + o));
        add_entry($sformatf("le_rd_s%0d_o%0d", s, o), 1'b0, tcb_pkg::TCB_LITTLE, s, 8 + o, '0);
        add_entry($sformatf("be_wr_s%0d_o%0d", s, o), 1'b1, tcb_pkg::TCB_BIG, s, 12 + o,
                  32'(32'h3D7B_1F59 + s*16 + o));
        add_entry($sformatf("be_rd_s%0d_o%0d", s, o), 1'b0, tcb_pkg::TCB_BIG, s, 12 + o, '0);
      end
    end
    // big endian lane pattern seen through a little endian word read
    add_entry("be_word_wr", 1'b1, tcb_pkg::TCB_BIG, 2, 16, 32'h1122_3344);
    add_entry("le_rd_after_be_word", 1'b0, tcb_pkg::TCB_LITTLE, 2, 16, '0);
    add_entry("be_half_wr_o2", 1'b1, tcb_pkg::TCB_BIG, 1, 18, 32'hEEEE_A1B2);
    add_entry("le_rd_after_be_half", 1'b0, tcb_pkg::TCB_LITTLE, 2, 16, '0);
    // narrow writes keep the other lanes
    add_entry("narrow_base_wr", 1'b1, tcb_pkg::TCB_LITTLE, 2, 20, 32'hA0B0_C0D0);
    add_entry("narrow_byte_wr", 1'b1, tcb_pkg::TCB_LITTLE, 0, 22, 32'hFFFF_FF5A);
    add_entry("narrow_word_rd", 1'b0, tcb_pkg::TCB_LITTLE, 2, 20, '0);
    add_entry("narrow_be_half_wr", 1'b1, tcb_pkg::TCB_BIG, 1, 20, 32'hFFFF_9A8B);
    add_entry("narrow_word_rd2", 1'b0, tcb_pkg::TCB_LITTLE, 2, 20, '0);
    // past the last word followed by word 0 that aliasing must not have hit
    add_entry("oor_word_wr", 1'b1, tcb_pkg::TCB_LITTLE, 2, DEPTH*BEN, 32'hDEAD_BEEF);
    add_entry("oor_word_rd", 1'b0, tcb_pkg::TCB_LITTLE, 2, DEPTH*BEN, '0);
    add_entry("oor_byte_rd_top", 1'b0, tcb_pkg::TCB_BIG, 0, 16'hFFFF, '0);
    add_entry("alias_word_rd", 1'b0, tcb_pkg::TCB_LITTLE, 2, 0, '0);
    // random stream of mostly low words with an occasional one out of range
    for (int unsigned i = 0; i < N_RND; i++) begin
      wen = (rand_bits(1) != 0);
      ndn = (rand_bits(1) != 0) ? tcb_pkg::TCB_BIG : tcb_pkg::TCB_LITTLE;
      s   = rand_bits(2) % 3;
      w   = rand_bits(4);
      if (rand_bits(3) == 0) begin
        w = w + DEPTH;
      end
      o = (rand_bits(2) >> s) << s;
      add_entry($sformatf("rnd_%0d", i), wen, ndn, s, w*BEN + o, rand_bits(32));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////////////////////

  // oldest due response is checked first and any transfer on the next edge is queued after
  always @(negedge clk) begin
    if (exp_due.size() != 0 && exp_due[0] == cyc) begin
      chk_name = exp_name.pop_front();
      chk_rsp  = exp_rsp.pop_front();
      void'(exp_due.pop_front());
      check_rsp(chk_name, chk_rsp, sub_rsp);
    end
    if (arst_n && sub_vld && sub_rdy) begin
      exp_rsp.push_back(model_access(sub_req));
      exp_name.push_back(cur_name);
      exp_due.push_back(cyc + `TCB_DLY);
    end
  end

  // limit grows with the table
  initial begin
    wait (tbl_done);
    wd_ns = (tbl_req.size() + DEPTH + 20) * 10 * 4;
    #(wd_ns * 1ns);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout, the run did not finish within %0d ns", wd_ns);
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    arst_n   = 1'b0;
    sub_vld  = 1'b0;
    sub_req  = '0;
    cur_name = "idle";
    foreach (shadow[i]) begin
      shadow[i] = 8'h00;
    end
    build_table();
    tbl_done = 1'b1;

    // 10 cycles in reset with quiet outputs
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_rdy("reset_rdy", 1'b0, sub_rdy);
    check_rsp("reset_rsp", '0, sub_rsp);
    @(posedge clk);
    arst_n <= 1'b1;

    // rdy low for exactly DEPTH cycles
    for (int unsigned i = 0; i < DEPTH; i++) begin
      @(negedge clk);
      check_rdy("clear_rdy_low", 1'b0, sub_rdy);
    end
    @(negedge clk);
    check_rdy("clear_rdy_high", 1'b1, sub_rdy);

    // back to back stream where rdy must stay high and every edge is a transfer
    for (int unsigned i = 0; i < tbl_req.size(); i++) begin
      @(posedge clk);
      sub_vld  <= 1'b1;
      sub_req  <= tbl_req[i];
      cur_name <= tbl_name[i];
      @(negedge clk);
      check_rdy(tbl_name[i], 1'b1, sub_rdy);
    end
    @(posedge clk);
    sub_vld <= 1'b0;
    sub_req <= '0;

    // let the last responses come out
    while (exp_due.size() != 0) begin
      @(negedge clk);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : tcb_sys_tb

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/tcb_pkg.sv
hdl/tcb_mem_pkg.sv
hdl/tcb_dly_pipe.sv
hdl/tcb_lib_logsize2byteena.sv
hdl/tcb_mem_sub.sv
hdl/tcb_sys_top.sv
tb/tcb_sys_properties.sv
tb/tcb_sys_tb.sv

//--- Makefile
SIM      ?= verilator
TOP      := tcb_sys_tb
FILELIST := build.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT     := --lint-only -Wall --timing --timescale 1ns/1ps
OBJ      := obj_dir
LOG      := sim.log
FAIL_MSG := TEST RESULT: FAIL
PASS_MSG := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)

run: build
	-./$(OBJ)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)
